// File: include/fetch_consts.svh
// assumes byte addresses with halfword lines; IDX_W and TAG_W must add up to ADDR_W minus 1
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// datapath widths
`define ADDR_W 16
`define INST_W 16

// cache geometry, one halfword per line
`define ICACHE_WAYS 2
`define ICACHE_SETS 16

// index is addr[4:1], bit 0 is the halfword offset
`define ICACHE_IDX_W 4

// tag is addr[15:5]
`define ICACHE_TAG_W 11

// first fetch address after reset
`define RESET_PC 16'h0000

`endif

// File: rtl/fetch_pkg.sv
// types for the fetch stage; widths come from the consts header, which must be on the include path
`default_nettype none
`include "fetch_consts.svh"

package fetch_pkg;

	typedef logic [`ADDR_W-1:0]       addr_t;    // byte address
	typedef logic [`INST_W-1:0]       inst_t;    // one instruction halfword
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_IDX_W-1:0] idx_t;
	typedef logic [`ICACHE_WAYS-1:0]  wayMask_t; // one bit per way

	// miss handler states
	typedef enum logic [1:0] {
		FILL_IDLE,  // looking up, no miss outstanding
		FILL_WAIT,  // request sent, waiting on memValid
		FILL_WRITE  // strobe the returned word into a way
	} fillState_t;

	// next pc source, hold means no load this edge
	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BRANCH,
		PC_JUMP,
		PC_HOLD
	} pcSrc_t;

endpackage

`default_nettype wire

// File: rtl/pcUnit.sv
// pc loads only with halt, stall and icStall low; an odd pc is flagged on err but never corrected
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module pcUnit (
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             halt,       // level, freezes pc
	input  wire logic             stall,      // level, from later stages
	input  wire logic             icStall,    // cache miss in progress
	input  wire logic             brTaken,
	input  wire fetch_pkg::addr_t brTarget,
	input  wire logic             jumpTaken,
	input  wire fetch_pkg::addr_t jumpTarget,
	output fetch_pkg::addr_t      pc,
	output fetch_pkg::addr_t      pcPlusTwo,
	output logic                  err         // pc not halfword aligned
);
	import fetch_pkg::*;

	pcSrc_t pcSrc;   // chosen source for this edge
	addr_t  nextPc;

	// any hold beats a redirect; branch over jump over sequential
	always_comb begin
		if (halt || stall || icStall)
			pcSrc = PC_HOLD;
		else if (brTaken)
			pcSrc = PC_BRANCH;
		else if (jumpTaken)
			pcSrc = PC_JUMP;
		else
			pcSrc = PC_SEQ;
	end

	always_comb begin
		case (pcSrc)
			PC_BRANCH: nextPc = brTarget;
			PC_JUMP:   nextPc = jumpTarget;
			PC_SEQ:    nextPc = pcPlusTwo;
			default:   nextPc = pc;     // hold
		endcase
	end

	// the pc register itself
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= addr_t'(`RESET_PC);
		end else if (pcSrc != PC_HOLD) begin
			pc <= nextPc;
		end
	end

	// halfword step, wraps at the top of memory
	assign pcPlusTwo = pc + addr_t'(2);

	// odd pc stays odd on sequential steps, only a redirect clears it
	assign err = pc[0];

endmodule

`default_nettype wire

// File: rtl/icacheWay.sv
// one way, one halfword per line; flush beats a fill on the same edge, tag and data have no reset
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module icacheWay (
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             flush,      // clears every valid bit
	input  wire fetch_pkg::addr_t pc,
	input  wire logic             fillStrobe,
	input  wire logic             fillSel,    // this way picked as victim
	input  wire fetch_pkg::addr_t fillPc,
	input  wire fetch_pkg::inst_t fillData,
	output logic                  wayHit,
	output fetch_pkg::inst_t      wayData
);
	import fetch_pkg::*;

	logic  validArr [`ICACHE_SETS];
	tag_t  tagArr   [`ICACHE_SETS];
	inst_t dataArr  [`ICACHE_SETS];

	idx_t lookIdx;
	tag_t lookTag;
	idx_t fillIdx;
	tag_t fillTag;
	logic fillEn;   // this way takes the fill

	// address split, bit 0 is the byte within the halfword
	assign lookIdx = pc[`ICACHE_IDX_W:1];
	assign lookTag = pc[`ADDR_W-1:`ICACHE_IDX_W+1];
	assign fillIdx = fillPc[`ICACHE_IDX_W:1];
	assign fillTag = fillPc[`ADDR_W-1:`ICACHE_IDX_W+1];

	assign fillEn = fillStrobe && fillSel;

	// lookup is purely combinational
	assign wayHit  = validArr[lookIdx] && (tagArr[lookIdx] == lookTag);
	assign wayData = dataArr[lookIdx];   // only meaningful on a hit

	// valid bits
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `ICACHE_SETS; i++)
				validArr[i] <= 1'b0;
		end else if (flush) begin
			for (int i = 0; i < `ICACHE_SETS; i++)
				validArr[i] <= 1'b0;   // a same-edge fill is dropped
		end else if (fillEn) begin
			validArr[fillIdx] <= 1'b1;
		end
	end

	// tag and data written on every fill, flush or not
	always_ff @(posedge clk) begin
		if (fillEn) begin
			tagArr[fillIdx]  <= fillTag;
			dataArr[fillIdx] <= fillData;
		end
	end

endmodule

`default_nettype wire

// File: rtl/hitSelect.sv
// assumes at most one way hits per set; victim choice is plain round robin, invalid ways not preferred
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module hitSelect (
	input  wire logic                               clk,
	input  wire logic                               rstN,
	input  wire fetch_pkg::addr_t                   pc,
	input  wire fetch_pkg::wayMask_t                wayHits,
	input  wire logic [`ICACHE_WAYS*`INST_W-1:0]    wayDatas,   // way 0 in the low word
	input  wire logic                               fillStrobe,
	input  wire fetch_pkg::addr_t                   fillPc,
	output logic                                    hit,
	output fetch_pkg::inst_t                        inst,
	output fetch_pkg::wayMask_t                     fillWay     // one-hot victim
);
	import fetch_pkg::*;

	localparam int PTR_W = $clog2(`ICACHE_WAYS);

	logic [PTR_W-1:0] victimPtr [`ICACHE_SETS];   // per-set round robin
	idx_t             lookIdx;
	idx_t             fillIdx;

	assign lookIdx = pc[`ICACHE_IDX_W:1];
	assign fillIdx = fillPc[`ICACHE_IDX_W:1];

	assign hit = |wayHits;

	// mux the hitting way, zero when nothing hits
	always_comb begin
		inst = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (wayHits[w])
				inst = wayDatas[w*`INST_W +: `INST_W];
		end
	end

	// pc is held during a miss, so its set is the one being filled
	assign fillWay = wayMask_t'(1) << victimPtr[lookIdx];

	// pointer moves on to the next way once a fill lands
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < `ICACHE_SETS; s++)
				victimPtr[s] <= '0;   // all sets start at way 0
		end else if (fillStrobe) begin
			if (victimPtr[fillIdx] == PTR_W'(`ICACHE_WAYS - 1))
				victimPtr[fillIdx] <= '0;
			else
				victimPtr[fillIdx] <= victimPtr[fillIdx] + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fillCtrl.sv
// one outstanding miss; memory must accept every memReq and answer with exactly one memValid
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fillCtrl (
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire fetch_pkg::addr_t pc,
	input  wire logic             hit,
	output logic                  memReq,      // one-cycle strobe
	output fetch_pkg::addr_t      memAddr,
	input  wire logic             memValid,    // one-cycle answer
	input  wire fetch_pkg::inst_t memData,
	output logic                  fillStrobe,
	output fetch_pkg::addr_t      fillPc,
	output fetch_pkg::inst_t      fillData
);
	import fetch_pkg::*;

	fillState_t state;
	fillState_t stateNext;
	logic       missDetect;   // even pc, no hit, nothing outstanding

	// odd pc never fetches
	assign missDetect = (state == FILL_IDLE) && !pc[0] && !hit;

	// request goes out in the miss cycle itself
	assign memReq  = missDetect;
	assign memAddr = pc;

	assign fillStrobe = (state == FILL_WRITE);

	always_comb begin
		stateNext = state;
		case (state)
			FILL_IDLE: begin
				if (missDetect)
					stateNext = FILL_WAIT;
			end
			FILL_WAIT: begin
				if (memValid)
					stateNext = FILL_WRITE;
			end
			FILL_WRITE: stateNext = FILL_IDLE;   // line lands this edge
			default:    stateNext = FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= FILL_IDLE;
		else
			state <= stateNext;
	end

	// miss address and returned word
	always_ff @(posedge clk) begin
		if (missDetect)
			fillPc <= pc;
		if ((state == FILL_WAIT) && memValid)
			fillData <= memData;
	end

endmodule

`default_nettype wire

// File: rtl/fetchTop.sv
// fetch stage top; misses take memory latency plus two cycles and the pc is frozen meanwhile
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetchTop (
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             halt,
	input  wire logic             stall,
	input  wire logic             flush,       // invalidate whole cache
	input  wire logic             brTaken,
	input  wire fetch_pkg::addr_t brTarget,
	input  wire logic             jumpTaken,
	input  wire fetch_pkg::addr_t jumpTarget,
	output fetch_pkg::inst_t      inst,
	output logic                  instValid,
	output fetch_pkg::addr_t      pcPlusTwo,
	output logic                  icStall,
	output logic                  err,
	output logic                  memReq,
	output fetch_pkg::addr_t      memAddr,
	input  wire logic             memValid,
	input  wire fetch_pkg::inst_t memData
);
	import fetch_pkg::*;

	addr_t                            pc;
	logic                             hit;
	logic                             fillStrobe;
	addr_t                            fillPc;
	inst_t                            fillData;
	wayMask_t                         fillWay;
	wayMask_t                         wayHits;
	logic [`ICACHE_WAYS*`INST_W-1:0]  wayDatas;

	pcUnit uPcUnit (
		.clk        (clk),
		.rstN       (rstN),
		.halt       (halt),
		.stall      (stall),
		.icStall    (icStall),
		.brTaken    (brTaken),
		.brTarget   (brTarget),
		.jumpTaken  (jumpTaken),
		.jumpTarget (jumpTarget),
		.pc         (pc),
		.pcPlusTwo  (pcPlusTwo),
		.err        (err)
	);

	fillCtrl uFillCtrl (
		.clk        (clk),
		.rstN       (rstN),
		.pc         (pc),
		.hit        (hit),
		.memReq     (memReq),
		.memAddr    (memAddr),
		.memValid   (memValid),
		.memData    (memData),
		.fillStrobe (fillStrobe),
		.fillPc     (fillPc),
		.fillData   (fillData)
	);

	// identical ways, each gets its bit of the victim mask
	for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : gWay
		icacheWay uWay (
			.clk        (clk),
			.rstN       (rstN),
			.flush      (flush),
			.pc         (pc),
			.fillStrobe (fillStrobe),
			.fillSel    (fillWay[g]),
			.fillPc     (fillPc),
			.fillData   (fillData),
			.wayHit     (wayHits[g]),
			.wayData    (wayDatas[g*`INST_W +: `INST_W])
		);
	end

	hitSelect uHitSelect (
		.clk        (clk),
		.rstN       (rstN),
		.pc         (pc),
		.wayHits    (wayHits),
		.wayDatas   (wayDatas),
		.fillStrobe (fillStrobe),
		.fillPc     (fillPc),
		.hit        (hit),
		.inst       (inst),
		.fillWay    (fillWay)
	);

	// err is pc[0]; an odd pc neither delivers nor stalls
	assign instValid = hit & ~err;
	assign icStall   = ~hit & ~err;

endmodule

`default_nettype wire

// File: verif/fetch_tb.sv
// random run against a cycle model in this file; memory is modeled here with a 1 to 6 cycle latency
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int NUM_CYCLES  = 3000;
	localparam int MAX_LAT     = 6;
	localparam int WATCHDOG_NS = NUM_CYCLES * (MAX_LAT + 2) * CLK_PERIOD + 200;   // all misses, worst case
	localparam int WAYS        = `ICACHE_WAYS;
	localparam int SETS        = `ICACHE_SETS;

	logic  clk;
	logic  rstN;
	logic  halt;
	logic  stall;
	logic  flush;
	logic  brTaken;
	addr_t brTarget;
	logic  jumpTaken;
	addr_t jumpTarget;
	inst_t inst;
	logic  instValid;
	addr_t pcPlusTwo;
	logic  icStall;
	logic  err;
	logic  memReq;
	addr_t memAddr;
	logic  memValid;
	inst_t memData;

	// reference model state, valid after the last rising edge
	addr_t mPc;
	logic  mValid [WAYS][SETS];
	addr_t mLine  [WAYS][SETS];   // full halfword address held per line
	int    mPtr   [SETS];         // round-robin victim per set
	logic  mWaiting;              // request out, no answer yet
	logic  mFillPending;          // line lands at the next edge
	addr_t mFillAddr;

	// memory responder
	inst_t  memWords [addr_t];    // filled lazily
	int     latLeft;
	addr_t  reqAddr;
	integer seed;
	int     hitCount;
	int     missCount;

	fetchTop uut (
		.clk        (clk),
		.rstN       (rstN),
		.halt       (halt),
		.stall      (stall),
		.flush      (flush),
		.brTaken    (brTaken),
		.brTarget   (brTarget),
		.jumpTaken  (jumpTaken),
		.jumpTarget (jumpTarget),
		.inst       (inst),
		.instValid  (instValid),
		.pcPlusTwo  (pcPlusTwo),
		.icStall    (icStall),
		.err        (err),
		.memReq     (memReq),
		.memAddr    (memAddr),
		.memValid   (memValid),
		.memData    (memData)
	);

	function automatic int setOf(addr_t a);
		return int'(a[`ICACHE_IDX_W:1]);   // bit 0 is the byte offset
	endfunction

	// memory word, drawn the first time an address is read
	function automatic inst_t memWord(addr_t a);
		if (!memWords.exists(a))
			memWords[a] = inst_t'($random(seed));
		return memWords[a];
	endfunction

	function automatic logic modelHit(addr_t a);
		logic found;
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			if (mValid[w][setOf(a)] && (mLine[w][setOf(a)] == a))
				found = 1'b1;
		end
		return found;
	endfunction

	// small window, 8 tags per set so lines get evicted and revisited
	function automatic addr_t randTarget();
		addr_t t;
		t = addr_t'($random(seed)) & 16'h00FE;
		if (({$random(seed)} % 16) == 0)
			t[0] = 1'b1;   // now and then misaligned
		return t;
	endfunction

	task automatic failRun(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkInst(input string name, input inst_t exp, input inst_t act);
		if (exp !== act)
			failRun($sformatf("ERROR %s expected %h actual %h at %0t", name, exp, act, $time));
	endtask

	task automatic checkAddr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act)
			failRun($sformatf("ERROR %s expected %h actual %h at %0t", name, exp, act, $time));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act)
			failRun($sformatf("ERROR %s expected %b actual %b at %0t", name, exp, act, $time));
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		failRun("timeout, the run did not finish in the expected time");
	end

	initial begin
		pcSrc_t src;
		logic   expHit;
		logic   expValid;
		logic   expStall;
		logic   expReq;
		int     s;

		seed       = 34;
		rstN       = 1'b0;
		halt       = 1'b0;
		stall      = 1'b0;
		flush      = 1'b0;
		brTaken    = 1'b0;
		brTarget   = '0;
		jumpTaken  = 1'b0;
		jumpTarget = '0;
		memValid   = 1'b0;
		memData    = '0;
		latLeft    = 0;
		reqAddr    = '0;
		hitCount   = 0;
		missCount  = 0;

		mPc          = addr_t'(`RESET_PC);
		mWaiting     = 1'b0;
		mFillPending = 1'b0;
		mFillAddr    = '0;
		for (int i = 0; i < SETS; i++) begin
			mPtr[i] = 0;
			for (int w = 0; w < WAYS; w++) begin
				mValid[w][i] = 1'b0;
				mLine[w][i]  = '0;
			end
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			// outputs have settled since the last rising edge
			expHit   = modelHit(mPc);
			expValid = expHit && !mPc[0];
			expStall = !expHit && !mPc[0];
			expReq   = !mWaiting && !mFillPending && !mPc[0] && !expHit;

			checkFlag("err", mPc[0], err);
			checkFlag("instValid", expValid, instValid);
			checkFlag("icStall", expStall, icStall);
			checkAddr("pcPlusTwo", mPc + addr_t'(2), pcPlusTwo);
			if (expValid)
				checkInst($sformatf("inst at pc %h", mPc), memWord(mPc), inst);
			if (memReq && (latLeft > 0))
				failRun("a second memory request came before the first was answered");
			checkFlag("memReq", expReq, memReq);
			if (memReq)
				checkAddr("memAddr", mPc, memAddr);
			if (expValid)
				hitCount++;
			if (memReq)
				missCount++;

			// responder answers once per request
			memValid = 1'b0;
			memData  = inst_t'($random(seed));   // junk while not valid
			if (latLeft > 0) begin
				latLeft--;
				if (latLeft == 0) begin
					memValid = 1'b1;
					memData  = memWord(reqAddr);
				end
			end
			if (memReq) begin
				latLeft = 1 + int'({$random(seed)} % MAX_LAT);
				reqAddr = memAddr;
			end

			halt       = ({$random(seed)} % 16) == 0;
			stall      = ({$random(seed)} % 8) == 0;
			flush      = ({$random(seed)} % 64) == 0;
			brTaken    = ({$random(seed)} % 8) == 0;
			jumpTaken  = ({$random(seed)} % 8) == 0;
			brTarget   = randTarget();
			jumpTarget = randTarget();

			// advance the model across the coming edge
			if (mFillPending) begin
				s = setOf(mFillAddr);
				if (!flush) begin   // flush wins over a same-edge fill
					mValid[mPtr[s]][s] = 1'b1;
					mLine[mPtr[s]][s]  = mFillAddr;
				end
				mPtr[s]      = (mPtr[s] + 1) % WAYS;   // moves even if flushed
				mFillPending = 1'b0;
			end
			if (flush) begin
				for (int i = 0; i < SETS; i++)
					for (int w = 0; w < WAYS; w++)
						mValid[w][i] = 1'b0;
			end
			if (mWaiting && memValid) begin
				mWaiting     = 1'b0;
				mFillPending = 1'b1;
			end
			if (expReq) begin
				mWaiting  = 1'b1;
				mFillAddr = mPc;
			end

			// branch over jump over sequential, any hold freezes
			if (halt || stall || expStall)
				src = PC_HOLD;
			else if (brTaken)
				src = PC_BRANCH;
			else if (jumpTaken)
				src = PC_JUMP;
			else
				src = PC_SEQ;
			case (src)
				PC_BRANCH: mPc = brTarget;
				PC_JUMP:   mPc = jumpTarget;
				PC_SEQ:    mPc = mPc + addr_t'(2);
				default:   mPc = mPc;
			endcase

			@(negedge clk);
		end

		if ((hitCount > 0) && (missCount > 0)) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			failRun("the run never saw both a cache hit and a cache miss");
		end
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/fetch_pkg.sv
rtl/pcUnit.sv
rtl/icacheWay.sv
rtl/hitSelect.sv
rtl/fillCtrl.sv
rtl/fetchTop.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench
TOP := fetch_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the simulator exits non-zero when the testbench fails
test:
	verilator --binary -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir
